// ==== verilog/uart_pkg.sv ====
package uart_pkg;

    // Clock and line rate
    localparam int CLK_FREQ     = 50_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

    // Entries in each byte FIFO
    localparam int FIFO_DEPTH = 16;

    // Derived widths
    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [7:0]            data_t;
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
    typedef logic [2:0]            bit_idx_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // One extra bit so a full FIFO can be told apart from an empty one
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

    typedef enum logic [2:0] {
        RX_IDLE      = 3'b000,
        RX_START_BIT = 3'b001,
        RX_DATA_BITS = 3'b010,
        RX_PARITY    = 3'b011,
        RX_STOP_BIT  = 3'b100
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE      = 3'b000,
        TX_START_BIT = 3'b001,
        TX_DATA_BITS = 3'b010,
        TX_PARITY    = 3'b011,
        TX_STOP_BIT  = 3'b100
    } tx_state_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  uart_pkg::data_t wr_data,
    input  logic           rd_en,
    output uart_pkg::data_t rd_data,
    output logic           full,
    output logic           empty
);
    import uart_pkg::*;

    data_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      do_wr;
    logic      do_rd;

    // Circular increment, kept explicit in case the depth is not a power of two
    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        fifo_ptr_t nxt;
        if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    // A read frees a slot in the same cycle, so write is allowed when full
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (!full || do_rd);

    // First word fall through: head entry is always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::data_t tx_data,
    input  logic            tx_write,
    output logic            tx_full,
    output logic            tx_serial
);
    import uart_pkg::*;

    tx_state_t state;
    baud_cnt_t baud_cnt;
    bit_idx_t  bit_idx;
    data_t     shift_reg;
    data_t     fifo_data;
    logic      parity_bit;
    logic      fifo_empty;
    logic      fifo_wr;
    logic      bit_done;
    logic      pop;

    // A write seen with tx_full high is refused, even if the FIFO pops on that edge
    assign fifo_wr = tx_write && !tx_full;

    sync_fifo u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr),
        .wr_data (tx_data),
        .rd_en   (pop),
        .rd_data (fifo_data),
        .full    (tx_full),
        .empty   (fifo_empty)
    );

    assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    // Pop from idle, or straight out of the stop bit for back to back frames
    assign pop = !fifo_empty &&
                 ((state == TX_IDLE) || (state == TX_STOP_BIT && bit_done));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (state == TX_IDLE || bit_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg  <= fifo_data;
            parity_bit <= ^fifo_data;
        end else if ((state == TX_START_BIT || state == TX_DATA_BITS) && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // tx_serial is registered and changes on the edge that enters each bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TX_IDLE;
            bit_idx   <= '0;
            tx_serial <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pop) begin
                        state     <= TX_START_BIT;
                        tx_serial <= 1'b0;
                    end
                end
                TX_START_BIT: begin
                    if (bit_done) begin
                        state     <= TX_DATA_BITS;
                        bit_idx   <= '0;
                        tx_serial <= shift_reg[0];
                    end
                end
                TX_DATA_BITS: begin
                    if (bit_done) begin
                        if (bit_idx == bit_idx_t'(7)) begin
                            state     <= TX_PARITY;
                            tx_serial <= parity_bit;
                        end else begin
                            bit_idx   <= bit_idx + 1'b1;
                            tx_serial <= shift_reg[0];
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_done) begin
                        state     <= TX_STOP_BIT;
                        tx_serial <= 1'b1;
                    end
                end
                TX_STOP_BIT: begin
                    if (bit_done) begin
                        state     <= pop ? TX_START_BIT : TX_IDLE;
                        tx_serial <= !pop;
                    end
                end
                default: begin
                    state     <= TX_IDLE;
                    tx_serial <= 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx_serial,
    input  logic            rx_ready,
    output logic            rx_valid,
    output logic            rx_error,
    output uart_pkg::data_t rx_data
);
    import uart_pkg::*;

    rx_state_t state;
    baud_cnt_t baud_cnt;
    bit_idx_t  bit_idx;
    data_t     shift_reg;
    logic      parity_rx;
    logic      half_tick;
    logic      bit_tick;
    logic      frame_ok;
    logic      fifo_wr;
    logic      fifo_full;
    logic      fifo_empty;

    sync_fifo u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr),
        .wr_data (shift_reg),
        .rd_en   (rx_ready),
        .rd_data (rx_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    assign rx_valid = !fifo_empty;

    // Half tick lands in the middle of the start bit, full ticks one period later each
    assign half_tick = (state == RX_START_BIT) &&
                       (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    assign bit_tick  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    // Even parity over data plus parity bit, high stop bit, room in the FIFO
    assign frame_ok = rx_serial && ((^shift_reg) == parity_rx) && !fifo_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (state == RX_IDLE || half_tick || bit_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (!rx_serial) begin
                        state <= RX_START_BIT;
                    end
                end
                RX_START_BIT: begin
                    // A start bit that went high again was only a glitch
                    if (half_tick) begin
                        state   <= rx_serial ? RX_IDLE : RX_DATA_BITS;
                        bit_idx <= '0;
                    end
                end
                RX_DATA_BITS: begin
                    if (bit_tick) begin
                        if (bit_idx == bit_idx_t'(7)) begin
                            state <= RX_PARITY;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_tick) begin
                        state <= RX_STOP_BIT;
                    end
                end
                RX_STOP_BIT: begin
                    if (bit_tick) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA_BITS && bit_tick) begin
            shift_reg <= {rx_serial, shift_reg[7:1]};
        end
        if (state == RX_PARITY && bit_tick) begin
            parity_rx <= rx_serial;
        end
    end

    // Verdict one clock after the stop sample, shift_reg holds still until next frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_wr  <= 1'b0;
            rx_error <= 1'b0;
        end else if (state == RX_STOP_BIT && bit_tick) begin
            fifo_wr  <= frame_ok;
            rx_error <= !frame_ok;
        end else begin
            fifo_wr  <= 1'b0;
            rx_error <= 1'b0;
        end
    end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
    input  logic            clk,
    input  logic            rst_n,

    // Transmit side
    input  uart_pkg::data_t tx_data,
    input  logic            tx_write,
    output logic            tx_full,
    output logic            tx_serial,

    // Receive side
    input  logic            rx_serial,
    input  logic            rx_ready,
    output uart_pkg::data_t rx_data,
    output logic            rx_valid,
    output logic            rx_error
);
    import uart_pkg::*;

    // The two sides share only clock and reset, loopback is wired outside
    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_write  (tx_write),
        .tx_full   (tx_full),
        .tx_serial (tx_serial)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_serial (rx_serial),
        .rx_ready  (rx_ready),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error),
        .rx_data   (rx_data)
    );

endmodule

// ==== verification/tb_uart.sv ====
`timescale 1ns/1ps

module tb_uart;
    import uart_pkg::*;

    localparam int NUM_ROWS   = 5;
    localparam int WAIT_LIMIT = 30 * CLKS_PER_BIT;

    // Row modes
    localparam int M_LOOP     = 0;
    localparam int M_BURST    = 1;
    localparam int M_BAD_PAR  = 2;
    localparam int M_BAD_STOP = 3;
    localparam int M_OVERFLOW = 4;

    logic  clk;
    logic  rst_n;
    data_t tx_data;
    logic  tx_write;
    logic  tx_full;
    logic  tx_serial;
    logic  rx_serial;
    logic  rx_ready;
    data_t rx_data;
    logic  rx_valid;
    logic  rx_error;

    // Line source select, the injector drives inject_line
    logic  use_inject;
    logic  inject_line;

    // Test table
    string row_name       [NUM_ROWS];
    int    row_mode       [NUM_ROWS];
    int    row_count      [NUM_ROWS];
    data_t row_seed       [NUM_ROWS];
    int    row_exp_err    [NUM_ROWS];
    int    row_exp_stored [NUM_ROWS];

    logic [31:0] lfsr_state;
    data_t       payload  [$];
    data_t       expect_q [$];
    int          errors;
    int          checks;
    int          err_pulses;
    int          got_bytes;
    logic        full_seen;

    uart_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_write  (tx_write),
        .tx_full   (tx_full),
        .tx_serial (tx_serial),
        .rx_serial (rx_serial),
        .rx_ready  (rx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error)
    );

    assign rx_serial = use_inject ? inject_line : tx_serial;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rx_error is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && rx_error) begin
            err_pulses++;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per payload bit
    function automatic data_t random_byte();
        data_t b;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
        return b;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // tx_full seen after an edge holds until the next edge, so it tells if the write is taken
    task automatic write_byte(input string name, input data_t d);
        int   waited;
        logic taken;
        waited   = 0;
        taken    = 1'b0;
        tx_data  = d;
        tx_write = 1'b1;
        while (!taken && waited < WAIT_LIMIT) begin
            taken = !tx_full;
            if (tx_full) begin
                full_seen = 1'b1;
            end
            tick();
            waited++;
        end
        tx_write = 1'b0;
        if (!taken) begin
            errors++;
            $display("%s: transmit FIFO never accepted a byte", name);
        end
    endtask

    // Waits for rx_valid, compares the head byte with the next expected one, then pops it
    task automatic take_byte(input string name, input logic keep_ready);
        int waited;
        waited = 0;
        while (!rx_valid && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (!rx_valid) begin
            errors++;
            $display("%s: rx_valid never came for an expected byte", name);
        end else begin
            if (expect_q.size() > 0) begin
                check(name, expect_q.pop_front(), rx_data);
            end else begin
                errors++;
                $display("%s: receiver stored a byte that should have been dropped", name);
            end
            got_bytes++;
            rx_ready = 1'b1;
            tick();
            rx_ready = keep_ready;
        end
    endtask

    // Start, data LSB first, even parity, stop, then one idle bit
    task automatic inject_frame(input data_t d, input logic flip_parity,
                                input logic low_stop);
        logic [10:0] frame;
        frame = {!low_stop, (^d) ^ flip_parity, d, 1'b0};
        for (int i = 0; i < 11; i++) begin
            inject_line = frame[i];
            repeat (CLKS_PER_BIT) tick();
        end
        inject_line = 1'b1;
        repeat (CLKS_PER_BIT) tick();
    endtask

    task automatic wait_errors(input string name, input int target);
        int waited;
        waited = 0;
        while (err_pulses < target && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (err_pulses < target) begin
            errors++;
            $display("%s: an expected rx_error pulse never came", name);
        end
    endtask

    task automatic run_row(input int r);
        string name;
        data_t d;
        name       = row_name[r];
        err_pulses = 0;
        got_bytes  = 0;
        full_seen  = 1'b0;
        payload.delete();
        expect_q.delete();
        use_inject = (row_mode[r] >= M_BAD_PAR);
        for (int i = 0; i < row_count[r]; i++) begin
            d = random_byte() ^ row_seed[r];
            payload.push_back(d);
            // Only good frames that find room in the receive FIFO are kept
            if (row_mode[r] < M_BAD_PAR || (row_mode[r] == M_OVERFLOW && i < FIFO_DEPTH)) begin
                expect_q.push_back(d);
            end
        end
        case (row_mode[r])
            M_LOOP: begin
                foreach (payload[i]) begin
                    write_byte(name, payload[i]);
                    take_byte(name, 1'b0);
                end
            end
            M_BURST: begin
                rx_ready = 1'b1;
                fork
                    begin
                        foreach (payload[i]) begin
                            write_byte(name, payload[i]);
                        end
                    end
                    begin
                        repeat (payload.size()) take_byte(name, 1'b1);
                    end
                join
                rx_ready = 1'b0;
                check({name, " tx_full seen"}, 1, full_seen);
            end
            default: begin
                foreach (payload[i]) begin
                    inject_frame(payload[i], row_mode[r] == M_BAD_PAR,
                                 row_mode[r] == M_BAD_STOP);
                end
                wait_errors(name, row_exp_err[r]);
            end
        endcase
        // Give any late verdict time to show, then drain what the receiver kept
        repeat (2 * CLKS_PER_BIT) tick();
        while (rx_valid && got_bytes <= FIFO_DEPTH + row_count[r]) begin
            take_byte(name, 1'b0);
        end
        check({name, " error pulses"}, row_exp_err[r], err_pulses);
        check({name, " stored bytes"}, row_exp_stored[r], got_bytes);
        check({name, " rx_valid after drain"}, 0, rx_valid);
        use_inject = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        tx_data     = '0;
        tx_write    = 1'b0;
        rx_ready    = 1'b0;
        use_inject  = 1'b0;
        inject_line = 1'b1;
        lfsr_state  = 32'he6fe8bd9;
        errors      = 0;
        checks      = 0;
        err_pulses  = 0;
        got_bytes   = 0;
        full_seen   = 1'b0;

        row_name       = '{"loopback", "burst", "bad_parity", "bad_stop", "overflow"};
        row_mode       = '{M_LOOP, M_BURST, M_BAD_PAR, M_BAD_STOP, M_OVERFLOW};
        row_count      = '{4, 20, 3, 3, 17};
        row_seed       = '{8'h00, 8'h5a, 8'h11, 8'h22, 8'h33};
        row_exp_err    = '{0, 0, 3, 3, 1};
        row_exp_stored = '{4, 20, 0, 0, 16};

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check("reset tx_serial", 1, tx_serial);
        check("reset tx_full", 0, tx_full);
        check("reset rx_valid", 0, rx_valid);
        check("reset rx_error", 0, rx_error);
        tick();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/uart_pkg.sv
verilog/sync_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
verification/tb_uart.sv
